// File: build.f
hw/obj_pkg.sv
hw/obj_table_ram.sv
hw/obj_scan.sv
hw/obj_draw.sv
hw/obj_line_buffer.sv
hw/obj_engine.sv
sim/obj_engine_sva.sv
sim/obj_engine_tb.sv

// File: hw/obj_draw.sv
// Fetches one sprite row from the pattern ROM and writes one pixel per cycle
// ROM side is a read-only Wishbone classic master, any number of wait states
// Pixels past x 511 are suppressed so a row never wraps back onto the screen
`timescale 1ns/100ps
`default_nettype none

module obj_draw (
    input  wire                     clk,
    input  wire                     rst,
    input  wire obj_pkg::draw_cmd_t cmd,
    input  wire                     start,
    output logic                    busy,
    output obj_pkg::wb_req_t        rom_req,
    input  wire obj_pkg::wb_rsp_t   rom_rsp,
    output logic                    wr_en,
    output obj_pkg::xpos_t          wr_x,
    output obj_pkg::pixel_t         wr_pixel
);

    // Fetch side
    logic               cyc_r;
    obj_pkg::rom_addr_t adr_r;
    obj_pkg::rom_addr_t fetch_adr;
    logic [3:0]         words_left;
    obj_pkg::word_t     hold;
    logic               hold_full;
    // Pixel side
    obj_pkg::word_t     shreg;
    logic [2:0]         pix_left;
    logic [9:0]         xcnt;
    obj_pkg::pal_t      pal_r;
    logic               hflip_r;
    obj_pkg::pen_t      pen;
    logic               consume;
    logic               fetch_go;

    // Held word moves to the shifter as the last pixel goes out
    assign consume  = hold_full && pix_left <= 3'd1;
    // One request at a time, and only with room for its data
    assign fetch_go = busy && !cyc_r && words_left != 4'd0 && (!hold_full || consume);

    // Mirrored rows read the words backwards and the pens from the low nibble
    assign pen = hflip_r ? shreg[3:0] : shreg[15:12];

    assign wr_en    = pix_left != 3'd0 && !xcnt[9];
    assign wr_x     = xcnt[8:0];
    assign wr_pixel = {pal_r, pen};

    assign rom_req.cyc = cyc_r;
    assign rom_req.stb = cyc_r;
    assign rom_req.we  = 1'b0;
    assign rom_req.sel = 2'b11;
    assign rom_req.adr = adr_r;
    assign rom_req.dat = 16'd0;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy       <= 1'b0;
            cyc_r      <= 1'b0;
            words_left <= 4'd0;
            hold_full  <= 1'b0;
            pix_left   <= 3'd0;
        end else if (start) begin
            busy       <= 1'b1;
            words_left <= {1'b0, cmd.width} + 4'd1;
            fetch_adr  <= cmd.hflip ? cmd.addr + {13'd0, cmd.width} : cmd.addr;
            xcnt       <= {1'b0, cmd.xpos};
            pal_r      <= cmd.pal;
            hflip_r    <= cmd.hflip;
        end else begin
            if (fetch_go) begin
                cyc_r      <= 1'b1;
                adr_r      <= fetch_adr;
                fetch_adr  <= hflip_r ? fetch_adr - 16'd1 : fetch_adr + 16'd1;
                words_left <= words_left - 4'd1;
            end
            // Pixel shifter
            if (pix_left != 3'd0) begin
                shreg    <= hflip_r ? shreg >> 4 : shreg << 4;
                pix_left <= pix_left - 3'd1;
                xcnt     <= xcnt + 10'd1;
            end
            if (consume) begin
                shreg     <= hold;
                pix_left  <= 3'd4;
                hold_full <= 1'b0;
            end
            // hold is never full while a request is open
            if (cyc_r && rom_rsp.ack) begin
                cyc_r     <= 1'b0;
                hold      <= rom_rsp.dat;
                hold_full <= 1'b1;
            end
            // Done with the last pixel written at this edge
            if (words_left == 4'd0 && !cyc_r && !hold_full && pix_left <= 3'd1) begin
                busy <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/obj_engine.sv
// Sprite engine top, CPU table port and pattern ROM port are Wishbone classic
// The buffer halves hold stale data for the first two lines after reset
`timescale 1ns/100ps
`default_nettype none

module obj_engine (
    input  wire                   clk,
    input  wire                   rst,
    input  wire obj_pkg::wb_req_t cpu_req,
    output obj_pkg::wb_rsp_t      cpu_rsp,
    output obj_pkg::wb_req_t      rom_req,
    input  wire obj_pkg::wb_rsp_t rom_rsp,
    input  wire                   hstart,
    input  wire                   lhbl,
    input  wire                   pxl_cen,
    input  wire obj_pkg::line_t   vrender,
    output obj_pkg::pixel_t       pxl,
    output logic                  pxl_valid
);

    // Table read path
    obj_pkg::tbl_addr_t tbl_addr;
    obj_pkg::word_t     tbl_data;
    // Draw command path
    obj_pkg::draw_cmd_t cmd;
    logic               start;
    logic               busy;
    // Buffer write path
    logic               wr_en;
    obj_pkg::xpos_t     wr_x;
    obj_pkg::pixel_t    wr_pixel;

    obj_table_ram u_table (
        .clk      (clk),
        .rst      (rst),
        .cpu_req  (cpu_req),
        .cpu_rsp  (cpu_rsp),
        .tbl_addr (tbl_addr),
        .tbl_data (tbl_data)
    );

    obj_scan u_scan (
        .clk      (clk),
        .rst      (rst),
        .hstart   (hstart),
        .vrender  (vrender),
        .tbl_addr (tbl_addr),
        .tbl_data (tbl_data),
        .cmd      (cmd),
        .start    (start),
        .busy     (busy)
    );

    obj_draw u_draw (
        .clk      (clk),
        .rst      (rst),
        .cmd      (cmd),
        .start    (start),
        .busy     (busy),
        .rom_req  (rom_req),
        .rom_rsp  (rom_rsp),
        .wr_en    (wr_en),
        .wr_x     (wr_x),
        .wr_pixel (wr_pixel)
    );

    obj_line_buffer u_line (
        .clk       (clk),
        .rst       (rst),
        .hstart    (hstart),
        .lhbl      (lhbl),
        .pxl_cen   (pxl_cen),
        .wr_en     (wr_en),
        .wr_x      (wr_x),
        .wr_pixel  (wr_pixel),
        .pxl       (pxl),
        .pxl_valid (pxl_valid)
    );

endmodule

`default_nettype wire

// File: hw/obj_line_buffer.sv
// Ping-pong line buffer, the back half is drawn while the front half is shown
// Memory has no reset, the halves are cleared by reading them during the first two lines
// Write rule is first writer wins, pen 0 never writes
`timescale 1ns/100ps
`default_nettype none

module obj_line_buffer (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  hstart,
    input  wire                  lhbl,
    input  wire                  pxl_cen,
    input  wire                  wr_en,
    input  wire obj_pkg::xpos_t  wr_x,
    input  wire obj_pkg::pixel_t wr_pixel,
    output obj_pkg::pixel_t      pxl,
    output logic                 pxl_valid
);

    obj_pkg::pixel_t mem [2 * obj_pkg::line_pixels];
    // Selects the front half
    logic            bank;
    // Bit 8 marks the end of the active pixels
    logic [8:0]      rd_x;
    logic [8:0]      wr_idx;
    logic [8:0]      rd_idx;
    logic            wr_ok;
    logic            rd_go;

    assign wr_idx = {~bank, wr_x[7:0]};
    assign rd_idx = {bank, rd_x[7:0]};

    // On screen, not transparent, nobody there yet
    assign wr_ok = wr_en && !wr_x[8] && wr_pixel[3:0] != 4'd0 && mem[wr_idx] == 10'd0;
    assign rd_go = lhbl && pxl_cen && !rd_x[8];

    always_ff @(posedge clk) begin
        if (rst) begin
            bank      <= 1'b0;
            rd_x      <= 9'd0;
            pxl_valid <= 1'b0;
        end else begin
            if (hstart) begin
                bank <= ~bank;
            end
            // Counter restarts each blanking period
            if (!lhbl) begin
                rd_x <= 9'd0;
            end else if (rd_go) begin
                rd_x <= rd_x + 9'd1;
            end
            pxl_valid <= rd_go;
        end
    end

    // Reads and writes always target different halves
    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_idx] <= wr_pixel;
        end
        if (rd_go) begin
            pxl         <= mem[rd_idx];
            mem[rd_idx] <= 10'd0;
        end
    end

endmodule

`default_nettype wire

// File: hw/obj_pkg.sv
// Shared sizes and types for the sprite engine
// Table format is fixed at 16 entries of 4 words, so nothing here is meant to be resized
// Pixel value zero is the empty or transparent code throughout
`default_nettype none

package obj_pkg;

    // Table and line geometry
    localparam int obj_count   = 16;
    localparam int obj_words   = 4;
    localparam int line_pixels = 256;

    typedef logic [5:0]  tbl_addr_t;
    typedef logic [15:0] word_t;
    typedef logic [15:0] rom_addr_t;
    // Bit 8 set means off screen
    typedef logic [8:0]  xpos_t;
    typedef logic [7:0]  line_t;
    typedef logic [3:0]  pen_t;
    typedef logic [5:0]  pal_t;
    // Palette in the high bits, pen in the low nibble
    typedef logic [9:0]  pixel_t;

    // Wishbone classic request, master to slave
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [1:0]  sel;
        logic [15:0] adr;
        word_t       dat;
    } wb_req_t;

    // Wishbone classic response, slave to master
    typedef struct packed {
        logic  ack;
        word_t dat;
    } wb_rsp_t;

    // One sprite row to draw
    typedef struct packed {
        xpos_t       xpos;
        rom_addr_t   addr;
        // Words minus one
        logic [2:0]  width;
        pal_t        pal;
        logic        hflip;
    } draw_cmd_t;

    // Each read state puts out the address of one entry word
    typedef enum logic [2:0] {
        idle,
        read_y,
        read_x,
        read_addr,
        read_attr,
        issue,
        wait_draw
    } scan_state_t;

endpackage

`default_nettype wire

// File: hw/obj_scan.sv
// Walks the sprite table once per line, from entry 0 up
// Issues one draw command per visible entry, waits for the draw to finish
// A new hstart aborts the walk, the sprites not reached are lost for that line
`timescale 1ns/100ps
`default_nettype none

module obj_scan (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     hstart,
    input  wire obj_pkg::line_t     vrender,
    output obj_pkg::tbl_addr_t      tbl_addr,
    input  wire obj_pkg::word_t     tbl_data,
    output obj_pkg::draw_cmd_t      cmd,
    output logic                    start,
    input  wire                     busy
);

    obj_pkg::scan_state_t state;
    logic [3:0]           entry;
    logic [1:0]           word_sel;
    // Line restarted, entry 0 runs once the draw is idle
    logic                 restart;
    logic                 last;
    obj_pkg::line_t       dy;
    obj_pkg::line_t       row;
    obj_pkg::xpos_t       xpos_r;
    logic                 hflip_r;
    obj_pkg::rom_addr_t   base_r;
    logic [3:0]           span;
    obj_pkg::rom_addr_t   row_off;

    assign last = entry == 4'(obj_pkg::obj_count - 1);

    // Word 0 height lives in the high byte, top in the low byte
    assign dy = vrender - tbl_data[7:0];

    // Row start offset, row times words per row
    assign span    = {1'b0, tbl_data[10:8]} + 4'd1;
    assign row_off = {8'd0, row} * {12'd0, span};

    // Address of the word that comes back next cycle
    always_comb begin
        case (state)
            obj_pkg::read_x:    word_sel = 2'd1;
            obj_pkg::read_addr: word_sel = 2'd2;
            obj_pkg::read_attr: word_sel = 2'd3;
            default:            word_sel = 2'd0;
        endcase
    end

    assign tbl_addr = {entry, word_sel};

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= obj_pkg::idle;
            entry   <= 4'd0;
            restart <= 1'b0;
            start   <= 1'b0;
        end else begin
            start <= 1'b0;
            if (hstart) begin
                // The draw in flight must end before entry 0
                state   <= obj_pkg::wait_draw;
                entry   <= 4'd0;
                restart <= 1'b1;
            end else begin
                case (state)
                    obj_pkg::read_y: begin
                        state <= obj_pkg::read_x;
                    end
                    obj_pkg::read_x: begin
                        // Word 0 on tbl_data, check the line range
                        if (tbl_data[15:8] != 8'd0 && dy < tbl_data[15:8]) begin
                            row   <= dy;
                            state <= obj_pkg::read_addr;
                        end else if (last) begin
                            state <= obj_pkg::idle;
                        end else begin
                            entry <= entry + 4'd1;
                            state <= obj_pkg::read_y;
                        end
                    end
                    obj_pkg::read_addr: begin
                        xpos_r  <= tbl_data[8:0];
                        hflip_r <= tbl_data[15];
                        state   <= obj_pkg::read_attr;
                    end
                    obj_pkg::read_attr: begin
                        base_r <= tbl_data;
                        state  <= obj_pkg::issue;
                    end
                    obj_pkg::issue: begin
                        // Word 3 on tbl_data, the draw is known to be idle here
                        cmd.xpos  <= xpos_r;
                        cmd.addr  <= base_r + row_off;
                        cmd.width <= tbl_data[10:8];
                        cmd.pal   <= tbl_data[5:0];
                        cmd.hflip <= hflip_r;
                        start     <= 1'b1;
                        state     <= obj_pkg::wait_draw;
                    end
                    obj_pkg::wait_draw: begin
                        // busy rises only the cycle after start
                        if (!busy && !start) begin
                            if (restart) begin
                                restart <= 1'b0;
                                state   <= obj_pkg::read_y;
                            end else if (last) begin
                                state <= obj_pkg::idle;
                            end else begin
                                entry <= entry + 4'd1;
                                state <= obj_pkg::read_y;
                            end
                        end
                    end
                    default: begin
                        state <= obj_pkg::idle;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/obj_table_ram.sv
// Sprite table, 64 words, CPU side is a Wishbone classic slave
// Only adr[5:0] is decoded, ack comes one cycle after cyc and stb
// Scan port has a registered read, it does not arbitrate with the CPU
`timescale 1ns/100ps
`default_nettype none

module obj_table_ram (
    input  wire                clk,
    input  wire                rst,
    input  wire obj_pkg::wb_req_t   cpu_req,
    output obj_pkg::wb_rsp_t        cpu_rsp,
    input  wire obj_pkg::tbl_addr_t tbl_addr,
    output obj_pkg::word_t          tbl_data
);

    obj_pkg::word_t     mem [obj_pkg::obj_count * obj_pkg::obj_words];
    obj_pkg::word_t     rd_dat;
    obj_pkg::tbl_addr_t cpu_adr;
    logic               ack_r;
    // Set after an ack until the CPU drops stb
    logic               served;
    logic               req_go;

    assign cpu_adr = cpu_req.adr[5:0];
    // New cycle only once the previous one has been released
    assign req_go  = cpu_req.cyc && cpu_req.stb && !ack_r && !served;

    // Handshake control
    always_ff @(posedge clk) begin
        if (rst) begin
            ack_r  <= 1'b0;
            served <= 1'b0;
        end else begin
            ack_r  <= req_go;
            served <= (served || ack_r) && cpu_req.cyc && cpu_req.stb;
        end
    end

    // CPU access, byte lanes follow sel
    always_ff @(posedge clk) begin
        if (req_go) begin
            rd_dat <= mem[cpu_adr];
            if (cpu_req.we && cpu_req.sel[0]) begin
                mem[cpu_adr][7:0] <= cpu_req.dat[7:0];
            end
            if (cpu_req.we && cpu_req.sel[1]) begin
                mem[cpu_adr][15:8] <= cpu_req.dat[15:8];
            end
        end
    end

    // Scan read, data one cycle after the address
    always_ff @(posedge clk) begin
        tbl_data <= mem[tbl_addr];
    end

    assign cpu_rsp.ack = ack_r;
    assign cpu_rsp.dat = rd_dat;

endmodule

`default_nettype wire

// File: sim/obj_engine_sva.sv
// Bound checks on both Wishbone ports and the draw handshake
// Violations are also counted in fail_count
`timescale 1ns/100ps
`default_nettype none

module obj_engine_sva (
    input wire                   clk,
    input wire                   rst,
    input wire obj_pkg::wb_req_t cpu_req,
    input wire obj_pkg::wb_rsp_t cpu_rsp,
    input wire obj_pkg::wb_req_t rom_req,
    input wire obj_pkg::wb_rsp_t rom_rsp,
    input wire                   start,
    input wire                   busy,
    input wire                   pxl_valid
);

    int fail_count;

    initial fail_count = 0;

    // Outputs idle on the first edge out of reset
    reset_idle: assert property (@(posedge clk)
        $fell(rst) |-> !cpu_rsp.ack && !rom_req.cyc && !rom_req.stb && !start && !busy
            && !pxl_valid)
        else begin
            fail_count++;
            $error("outputs not idle after reset");
        end

    // CPU ack only inside a strobe
    cpu_ack_stb: assert property (@(posedge clk) disable iff (rst)
        cpu_rsp.ack |-> cpu_req.cyc && cpu_req.stb)
        else begin
            fail_count++;
            $error("CPU ack without cyc and stb");
        end
    // One cycle after stb rises, never again while stb stays high
    cpu_ack_once: assert property (@(posedge clk) disable iff (rst)
        cpu_rsp.ack |-> $past(cpu_req.stb) && !$past(cpu_req.stb, 2))
        else begin
            fail_count++;
            $error("CPU ack not a single ack one cycle after stb");
        end

    // ROM request held until the slave answers
    rom_hold: assert property (@(posedge clk) disable iff (rst)
        rom_req.cyc && !rom_rsp.ack |=> rom_req.cyc && rom_req.stb && $stable(rom_req.adr))
        else begin
            fail_count++;
            $error("ROM request changed before ack");
        end

    // Draw start only while idle, busy follows on the next edge
    start_idle: assert property (@(posedge clk) disable iff (rst)
        start |-> !busy ##1 busy)
        else begin
            fail_count++;
            $error("draw start handshake broken");
        end

endmodule

bind obj_engine obj_engine_sva sva0 (
    .clk       (clk),
    .rst       (rst),
    .cpu_req   (cpu_req),
    .cpu_rsp   (cpu_rsp),
    .rom_req   (rom_req),
    .rom_rsp   (rom_rsp),
    .start     (start),
    .busy      (busy),
    .pxl_valid (pxl_valid)
);

`default_nettype wire

// File: sim/obj_engine_tb.sv
// Sprite engine testbench, 768 clocks per line, pixels on every 2nd clock
// The first two lines after reset show stale buffer data and are not compared
// Pattern ROM answers after 0 to 3 wait states, patterns only below 0x1000
`timescale 1ns/100ps
`default_nettype none

module obj_engine_tb;

    localparam int run_lines   = 49;
    localparam int watchdog_ns = (run_lines + 4) * 768 * 4;

    logic             clk = 1'b0;
    logic             rst;
    obj_pkg::wb_req_t cpu_req;
    obj_pkg::wb_rsp_t cpu_rsp;
    obj_pkg::wb_req_t rom_req;
    obj_pkg::wb_rsp_t rom_rsp;
    logic             hstart;
    logic             lhbl;
    logic             pxl_cen;
    obj_pkg::line_t   vrender;
    obj_pkg::pixel_t  pxl;
    logic             pxl_valid;

    // Shadow copies of the table and the ROM, expected line
    obj_pkg::word_t   tbl_sh [64];
    obj_pkg::word_t   rom [65536];
    obj_pkg::pixel_t  exp_line [256];
    logic [31:0]      lfsr = 32'd90270;

    obj_engine dut0 (.*);

    always #2 clk = ~clk;

    task automatic report_fail(input string line);
        $display("%s", line);
        $display("** FAIL **");
        $fatal(1);
    endtask

    // Taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[14:0], lfsr[0]};
        end
    endtask

    // One Wishbone classic access, ack expected on the first edge after stb
    task automatic bus_access(input logic wr, input obj_pkg::tbl_addr_t a,
                              input obj_pkg::word_t d, input logic [1:0] sel,
                              output obj_pkg::word_t q);
        int waited;
        cpu_req = '{cyc: 1'b1, stb: 1'b1, we: wr, sel: sel, adr: {10'd0, a}, dat: d};
        waited  = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!cpu_rsp.ack && waited < 8);
        assert (cpu_rsp.ack) else report_fail("CPU port gave no ack within 8 cycles");
        assert (waited == 1) else report_fail("CPU ack did not come one cycle after stb");
        q = cpu_rsp.dat;
        // Strobe stays up past the ack, no second ack may follow
        repeat (2) @(negedge clk);
        cpu_req = '0;
        @(negedge clk);
    endtask

    task automatic write_word(input obj_pkg::tbl_addr_t a, input obj_pkg::word_t d,
                              input logic [1:0] sel);
        obj_pkg::word_t q;
        bus_access(1'b1, a, d, sel, q);
        // Byte lanes
        if (sel[0]) begin
            tbl_sh[a][7:0] = d[7:0];
        end
        if (sel[1]) begin
            tbl_sh[a][15:8] = d[15:8];
        end
    endtask

    task automatic verify_word(input obj_pkg::tbl_addr_t a);
        obj_pkg::word_t q;
        bus_access(1'b0, a, 16'd0, 2'b11, q);
        assert (q == tbl_sh[a])
            else report_fail($sformatf("[FAIL] cpu_rsp.dat=0x%04h expected 0x%04h", q, tbl_sh[a]));
    endtask

    task automatic set_entry(input logic [3:0] e, input obj_pkg::line_t top,
                             input logic [7:0] h, input obj_pkg::xpos_t x, input logic flip,
                             input obj_pkg::rom_addr_t base, input logic [2:0] wm1,
                             input obj_pkg::pal_t pal);
        write_word({e, 2'd0}, {h, top}, 2'b11);
        write_word({e, 2'd1}, {flip, 6'd0, x}, 2'b11);
        write_word({e, 2'd2}, base, 2'b11);
        write_word({e, 2'd3}, {5'd0, wm1, 2'd0, pal}, 2'b11);
    endtask

    // Expected line from the entry layout, lower entry wins, pen 0 transparent
    task automatic build_expected(input obj_pkg::line_t v);
        obj_pkg::word_t     w0;
        obj_pkg::word_t     w1;
        obj_pkg::word_t     w3;
        obj_pkg::line_t     dy;
        obj_pkg::rom_addr_t adr;
        obj_pkg::pen_t      pen;
        int                 words;
        int                 x;
        int                 k;
        int                 nib;
        for (int i = 0; i < 256; i++) begin
            exp_line[i] = '0;
        end
        for (int e = 0; e < 16; e++) begin
            w0 = tbl_sh[e * 4];
            w1 = tbl_sh[e * 4 + 1];
            w3 = tbl_sh[e * 4 + 3];
            dy = v - w0[7:0];
            if (w0[15:8] != 8'd0 && dy < w0[15:8]) begin
                words = w3[10:8] + 1;
                for (int i = 0; i < words * 4; i++) begin
                    x   = w1[8:0] + i;
                    // Mirrored: last word first, low pen first
                    k   = w1[15] ? words - 1 - i / 4 : i / 4;
                    nib = w1[15] ? i % 4 : 3 - i % 4;
                    adr = tbl_sh[e * 4 + 2] + dy * words + k;
                    pen = rom[adr][nib * 4 +: 4];
                    if (x < 256 && pen != 4'd0 && exp_line[x] == '0) begin
                        exp_line[x] = {w3[5:0], pen};
                    end
                end
            end
        end
    endtask

    // One video line, outputs checked at each falling edge before the inputs move
    task automatic run_line(input int n);
        logic rd_prev;
        int   px;
        if (n >= 2) begin
            build_expected(8'(n - 1));
        end
        rd_prev = 1'b0;
        px      = 0;
        for (int c = 0; c < 768; c++) begin
            assert (pxl_valid == rd_prev)
                else report_fail($sformatf("[FAIL] pxl_valid=0x%0h expected 0x%0h",
                                           pxl_valid, rd_prev));
            if (pxl_valid && n >= 2) begin
                assert (pxl == exp_line[px])
                    else report_fail($sformatf("[FAIL] pxl=0x%03h expected 0x%03h line %0d x %0d",
                                               pxl, exp_line[px], n - 1, px));
            end
            if (pxl_valid) begin
                px++;
            end
            hstart  = c == 0;
            lhbl    = c >= 128 && c < 640;
            pxl_cen = c % 2 == 0;
            if (c == 0) begin
                vrender = 8'(n);
            end
            rd_prev = lhbl && pxl_cen;
            @(negedge clk);
        end
    endtask

    // Pattern ROM slave
    initial begin
        logic [15:0] r;
        rom_rsp = '0;
        forever begin
            @(negedge clk);
            if (rom_req.cyc && rom_req.stb) begin
                take_bits(2, r);
                repeat (r[1:0]) @(negedge clk);
                rom_rsp.dat = rom[rom_req.adr];
                rom_rsp.ack = 1'b1;
                @(negedge clk);
                rom_rsp.ack = 1'b0;
            end
        end
    end

    initial begin
        #(watchdog_ns);
        report_fail("watchdog expired before all lines were checked");
    end

    always @(negedge clk) begin
        if (dut0.sva0.fail_count != 0) begin
            report_fail("a bound assertion on the DUT ports failed");
        end
    end

    initial begin
        obj_pkg::word_t a;
        obj_pkg::word_t b;
        rst     = 1'b1;
        cpu_req = '0;
        hstart  = 1'b0;
        lhbl    = 1'b0;
        pxl_cen = 1'b0;
        vrender = '0;
        // AND of two random words, pen 0 about a third of the time
        for (int i = 0; i < 65536; i++) begin
            take_bits(16, a);
            take_bits(16, b);
            rom[i] = i < 4096 ? a & b : 16'd0;
        end
        repeat (2) @(negedge clk);
        rst = 1'b0;
        // Byte lanes on the CPU port
        write_word(6'd60, 16'h1234, 2'b11);
        write_word(6'd60, 16'hABCD, 2'b01);
        verify_word(6'd60);
        write_word(6'd60, 16'hEF00, 2'b10);
        verify_word(6'd60);
        for (int i = 0; i < 64; i++) begin
            write_word(6'(i), 16'd0, 2'b11);
        end
        // Plain, overlapping, mirrored, clipped, disabled, wrapped and off screen
        set_entry(4'd0, 8'd10, 8'd4, 9'd40, 1'b0, 16'h0100, 3'd1, 6'd5);
        set_entry(4'd1, 8'd11, 8'd4, 9'd44, 1'b0, 16'h0200, 3'd2, 6'd6);
        set_entry(4'd2, 8'd20, 8'd3, 9'd100, 1'b1, 16'h0300, 3'd2, 6'd9);
        set_entry(4'd3, 8'd20, 8'd3, 9'd150, 1'b0, 16'h0300, 3'd2, 6'd10);
        set_entry(4'd4, 8'd30, 8'd2, 9'd250, 1'b0, 16'h0400, 3'd3, 6'd12);
        set_entry(4'd5, 8'd10, 8'd0, 9'd60, 1'b0, 16'h0500, 3'd7, 6'd1);
        set_entry(4'd6, 8'd36, 8'd2, 9'd0, 1'b0, 16'h0600, 3'd7, 6'd20);
        set_entry(4'd7, 8'd250, 8'd12, 9'd200, 1'b0, 16'h0800, 3'd0, 6'd33);
        set_entry(4'd8, 8'd36, 8'd2, 9'd64, 1'b1, 16'h0700, 3'd7, 6'd21);
        set_entry(4'd10, 8'd40, 8'd3, 9'd300, 1'b0, 16'h0900, 3'd1, 6'd2);
        set_entry(4'd11, 8'd40, 8'd3, 9'd252, 1'b1, 16'h0A00, 3'd1, 6'd3);
        verify_word(6'd29);
        for (int n = 0; n < run_lines; n++) begin
            run_line(n);
        end
        if (dut0.sva0.fail_count == 0) begin
            $display("** PASS **");
            $finish;
        end else begin
            report_fail($sformatf("bound assertions failed %0d times", dut0.sva0.fail_count));
        end
    end

endmodule

`default_nettype wire
